/* coproc_issue_decoder.sv */
// Offload issue decoder
`timescale 1ns/1ps

module coproc_issue_decoder #(
  parameter int unsigned Vlen    = rvv_pkg::VlenDefault,
  parameter int unsigned IdWidth = xif_pkg::IdWidth
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               issue_valid_i,
  input  xif_pkg::instr_t    issue_instr_i,
  input  logic [IdWidth-1:0] issue_id_i,
  output logic               issue_ready_o,
  output logic               issue_accept_o,
  output logic               issue_writeback_o,
  output logic [1:0]         issue_register_read_o,
  input  logic               register_valid_i,
  input  logic [IdWidth-1:0] register_id_i,
  input  xif_pkg::xreg_t     register_rs2_i,
  input  logic               full_i,
  input  logic               flush_i,
  input  logic               drain_i,
  input  logic               arch_vill_i,
  output logic               push_o,
  output logic               push_cfg_o,
  output xif_pkg::rd_addr_t  push_rd_o
);
  import rvv_pkg::*;

  typedef enum logic [1:0] {
    Run,
    StallVsetvl,
    Drain
  } state_e;

  state_e             state_d, state_q;
  logic               spec_vill_d, spec_vill_q;
  logic [IdWidth-1:0] stall_id_d, stall_id_q;
  logic               opv, cfg;
  vtype_t             imm_vt, reg_vt;

  assign opv    = issue_instr_i[6:0] == OpcodeOpV;
  assign cfg    = is_cfg(issue_instr_i);
  assign imm_vt = vtype_from_bits(imm_vtype(issue_instr_i), Vlen);
  assign reg_vt = vtype_from_bits(register_rs2_i, Vlen);

  ////////////////////////////////////////////////////////////
  // Issue response
  ////////////////////////////////////////////////////////////

  assign issue_ready_o = issue_valid_i && state_q == Run && !full_i && !flush_i && !drain_i;

  always_comb begin
    issue_accept_o        = 1'b0;
    issue_writeback_o     = 1'b0;
    issue_register_read_o = 2'b00;
    if (cfg) begin
      issue_accept_o    = 1'b1;
      issue_writeback_o = issue_instr_i[11:7] != 5'd0;
      if (is_vsetvl(issue_instr_i)) begin
        issue_register_read_o = 2'b11;
      end else if (!is_vsetivli(issue_instr_i)) begin
        issue_register_read_o = 2'b01;
      end
    end else if (opv) begin
      // Arithmetic is only taken under a legal vtype
      issue_accept_o = !spec_vill_q;
    end
  end

  assign push_o     = issue_ready_o && issue_accept_o;
  assign push_cfg_o = cfg;
  assign push_rd_o  = issue_instr_i[11:7];

  ////////////////////////////////////////////////////////////
  // Speculative vtype and stall FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    spec_vill_d = spec_vill_q;
    stall_id_d  = stall_id_q;
    unique case (state_q)
      Run: begin
        if (push_o && cfg) begin
          if (is_vsetvl(issue_instr_i)) begin
            // New vtype is only known once rs2 arrives
            state_d    = StallVsetvl;
            stall_id_d = issue_id_i;
          end else begin
            spec_vill_d = imm_vt[VillBit];
          end
        end
      end
      StallVsetvl: begin
        if (register_valid_i && register_id_i == stall_id_q) begin
          spec_vill_d = reg_vt[VillBit];
          state_d     = Run;
        end
      end
      Drain: begin
        // Survivors have retired, so the architectural state is current
        if (!drain_i) begin
          spec_vill_d = arch_vill_i;
          state_d     = Run;
        end
      end
      default: state_d = Run;
    endcase
    if (flush_i) begin
      state_d = Drain;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Run;
      spec_vill_q <= 1'b1;
      stall_id_q  <= '0;
    end else begin
      state_q     <= state_d;
      spec_vill_q <= spec_vill_d;
      stall_id_q  <= stall_id_d;
    end
  end

  // A taken vsetvl holds off the next issue
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_o && cfg && is_vsetvl(issue_instr_i) |=> !issue_ready_o);

endmodule

/* flist.f */
xif_pkg.sv
rvv_pkg.sv
coproc_issue_decoder.sv
instr_ring_buffer.sv
vcfg_execute.sv
result_port.sv
vcoproc_top.sv
tb_vcoproc.sv

/* instr_ring_buffer.sv */
// In-order offload instruction buffer
`timescale 1ns/1ps

module instr_ring_buffer #(
  parameter int unsigned Depth   = 4,
  parameter int unsigned IdWidth = xif_pkg::IdWidth
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               push_i,
  input  logic [IdWidth-1:0] push_id_i,
  input  xif_pkg::instr_t    push_instr_i,
  input  logic               push_cfg_i,
  input  xif_pkg::rd_addr_t  push_rd_i,
  input  logic [1:0]         push_needs_rs_i,
  input  logic               register_valid_i,
  input  logic [IdWidth-1:0] register_id_i,
  input  xif_pkg::xreg_t     register_rs1_i,
  input  xif_pkg::xreg_t     register_rs2_i,
  output logic               register_ready_o,
  input  logic               commit_valid_i,
  input  logic [IdWidth-1:0] commit_id_i,
  input  logic               commit_kill_i,
  output logic               full_o,
  output logic               flush_o,
  output logic               drain_o,
  output logic               exec_valid_o,
  input  logic               exec_ready_i,
  output logic [IdWidth-1:0] exec_id_o,
  output xif_pkg::instr_t    exec_instr_o,
  output logic               exec_cfg_o,
  output xif_pkg::rd_addr_t  exec_rd_o,
  output xif_pkg::xreg_t     exec_rs1_o,
  output xif_pkg::xreg_t     exec_rs2_o
);
  import xif_pkg::*;

  localparam int unsigned PtrW = $clog2(Depth);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [PtrW:0]   cnt_t;

  // Entry payload
  logic [IdWidth-1:0] id_q    [Depth];
  instr_t             instr_q [Depth];
  rd_addr_t           rd_q    [Depth];
  xreg_t              rs1_q   [Depth];
  xreg_t              rs2_q   [Depth];
  logic [Depth-1:0]   cfg_q;

  // Entry state
  logic [Depth-1:0]   committed_q;
  logic [Depth-1:0]   rs_valid_q;
  ptr_t               head_q;
  ptr_t               tail;
  cnt_t               count_q, count_d;
  logic               drain_q;

  ptr_t               age [Depth];
  logic [Depth-1:0]   live, reg_hit, commit_hit;
  cnt_t               kept;
  logic               commit, kill, pop;

  assign commit = commit_valid_i && !commit_kill_i;
  assign kill   = commit_valid_i && commit_kill_i;
  assign tail   = head_q + ptr_t'(count_q);

  always_comb begin
    kept = '0;
    for (int i = 0; i < Depth; i++) begin
      age[i]        = ptr_t'(i) - head_q;
      live[i]       = cnt_t'(age[i]) < count_q;
      reg_hit[i]    = live[i] && !rs_valid_q[i] && id_q[i] == register_id_i;
      commit_hit[i] = live[i] && id_q[i] == commit_id_i;
      // Committed entries form the oldest part of the buffer
      kept          = kept + cnt_t'(live[i] && committed_q[i]);
    end
  end

  assign register_ready_o = register_valid_i && |reg_hit;
  assign full_o           = count_q == cnt_t'(Depth);
  assign flush_o          = kill;
  assign drain_o          = drain_q && count_q != '0;

  ////////////////////////////////////////////////////////////
  // Head release
  ////////////////////////////////////////////////////////////

  assign exec_valid_o = count_q != '0 && committed_q[head_q] && rs_valid_q[head_q];
  assign pop          = exec_valid_o && exec_ready_i;
  assign exec_id_o    = id_q[head_q];
  assign exec_instr_o = instr_q[head_q];
  assign exec_cfg_o   = cfg_q[head_q];
  assign exec_rd_o    = rd_q[head_q];
  assign exec_rs1_o   = rs1_q[head_q];
  assign exec_rs2_o   = rs2_q[head_q];

  always_comb begin
    if (kill) begin
      count_d = kept - cnt_t'(pop);
    end else begin
      count_d = count_q + cnt_t'(push_i) - cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q      <= '0;
      count_q     <= '0;
      drain_q     <= 1'b0;
      committed_q <= '0;
      rs_valid_q  <= '0;
    end else begin
      head_q  <= head_q + ptr_t'(pop);
      count_q <= count_d;
      if (kill) begin
        drain_q <= 1'b1;
      end else if (count_q == '0) begin
        drain_q <= 1'b0;
      end
      for (int i = 0; i < Depth; i++) begin
        if (register_valid_i && reg_hit[i]) begin
          rs_valid_q[i] <= 1'b1;
        end
        if (commit && commit_hit[i]) begin
          committed_q[i] <= 1'b1;
        end
      end
      if (push_i) begin
        rs_valid_q[tail]  <= push_needs_rs_i == 2'b00;
        // Commit may come in the same cycle as the issue
        committed_q[tail] <= commit && commit_id_i == push_id_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[tail]    <= push_id_i;
      instr_q[tail] <= push_instr_i;
      cfg_q[tail]   <= push_cfg_i;
      rd_q[tail]    <= push_rd_i;
    end
    for (int i = 0; i < Depth; i++) begin
      if (register_valid_i && reg_hit[i]) begin
        rs1_q[i] <= register_rs1_i;
        rs2_q[i] <= register_rs2_i;
      end
    end
  end

  // The decoder must hold issue while the buffer is full
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);

endmodule

/* result_port.sv */
// Result holding register
`timescale 1ns/1ps

module result_port #(
  parameter int unsigned IdWidth = xif_pkg::IdWidth
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               res_valid_i,
  output logic               res_ready_o,
  input  logic [IdWidth-1:0] res_id_i,
  input  rvv_pkg::vl_t       res_data_i,
  input  xif_pkg::rd_addr_t  res_rd_i,
  input  logic               res_we_i,
  output logic               result_valid_o,
  input  logic               result_ready_i,
  output logic [IdWidth-1:0] result_id_o,
  output xif_pkg::xreg_t     result_data_o,
  output xif_pkg::rd_addr_t  result_rd_o,
  output logic               result_we_o
);

  logic load;

  // Free when empty or drained in this cycle
  assign res_ready_o = !result_valid_o || result_ready_i;
  assign load        = res_valid_i && res_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_o <= 1'b0;
    end else if (load) begin
      result_valid_o <= 1'b1;
    end else if (result_ready_i) begin
      result_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      result_id_o   <= res_id_i;
      result_data_o <= res_data_i;
      result_rd_o   <= res_rd_i;
      result_we_o   <= res_we_i;
    end
  end

  // A pending result holds until the core takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_id_o) &&
      $stable(result_data_o) && $stable(result_rd_o) && $stable(result_we_o));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module tb_vcoproc -o sim_vcoproc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_vcoproc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx ">>> PASS" "$LOG"; then
  exit 0
fi
exit 1

/* rvv_pkg.sv */
// Vector configuration definitions
package rvv_pkg;

  // OP-V major opcode and the funct3 of vsetvli, vsetivli and vsetvl
  parameter logic [6:0] OpcodeOpV = 7'b1010111;
  parameter logic [2:0] Funct3Cfg = 3'b111;

  // Default vector register length in bits
  parameter int unsigned VlenDefault = 256;

  // Layout: [7] vill, [6] vma, [5] vta, [4:3] vsew, [2:0] vlmul
  typedef logic [7:0] vtype_t;
  typedef logic [xif_pkg::Xlen-1:0] vl_t;

  parameter int unsigned VillBit = 7;
  parameter vtype_t VtypeIll = 8'h80;

  typedef enum logic [1:0] {
    Sew8  = 2'd0,
    Sew16 = 2'd1,
    Sew32 = 2'd2,
    Sew64 = 2'd3
  } sew_e;

  ////////////////////////////////////////////////////////////
  // Configuration instruction helpers
  ////////////////////////////////////////////////////////////

  function automatic logic is_cfg(input xif_pkg::instr_t instr);
    return instr[6:0] == OpcodeOpV && instr[14:12] == Funct3Cfg;
  endfunction

  function automatic logic is_vsetvl(input xif_pkg::instr_t instr);
    return instr[31:30] == 2'b10;
  endfunction

  function automatic logic is_vsetivli(input xif_pkg::instr_t instr);
    return instr[31:30] == 2'b11;
  endfunction

  // Immediate vtype field, zero extended with its reserved bits
  function automatic vl_t imm_vtype(input xif_pkg::instr_t instr);
    if (is_vsetivli(instr)) begin
      return vl_t'(instr[29:20]);
    end
    return vl_t'(instr[30:20]);
  endfunction

  // VLEN * LMUL / SEW, zero for vill or fractional LMUL
  function automatic vl_t vlmax(input int unsigned vlen, input vtype_t vt);
    vl_t scaled;
    scaled = vl_t'(vlen) << vt[1:0];
    if (vt[VillBit] || vt[2]) begin
      return '0;
    end
    case (sew_e'(vt[4:3]))
      Sew8:    return scaled >> 3;
      Sew16:   return scaled >> 4;
      Sew32:   return scaled >> 5;
      default: return scaled >> 6;
    endcase
  endfunction

  // Reserved bits, SEW above 64 or fractional LMUL give vill
  function automatic vtype_t vtype_from_bits(input vl_t raw, input int unsigned vlen);
    vtype_t vt;
    vt = {1'b0, raw[7:6], raw[4:3], raw[2:0]};
    if (raw[xif_pkg::Xlen-1:8] != '0 || raw[5] || raw[2]) begin
      vt = VtypeIll;
    end else if (vlmax(vlen, vt) == '0) begin
      vt = VtypeIll;
    end
    return vt;
  endfunction

endpackage

/* tb_vcoproc.sv */
// Offload front end testbench
`timescale 1ns/1ps

module tb_vcoproc;
  localparam int unsigned Vlen  = 256;
  localparam int unsigned Depth = 4;
  localparam logic [6:0]  OpV   = 7'b1010111;

  logic        clk_i, rst_ni;
  logic        issue_valid_i, issue_ready_o, issue_accept_o, issue_writeback_o;
  logic [1:0]  issue_register_read_o;
  logic [31:0] issue_instr_i;
  logic [3:0]  issue_id_i;
  logic        register_valid_i, register_ready_o;
  logic [3:0]  register_id_i;
  logic [31:0] register_rs1_i, register_rs2_i;
  logic        commit_valid_i, commit_kill_i;
  logic [3:0]  commit_id_i;
  logic        result_valid_o, result_ready_i, result_we_o;
  logic [3:0]  result_id_o;
  logic [31:0] result_data_o;
  logic [4:0]  result_rd_o;

  // Expected results in issue order
  logic [3:0]  exp_id_a   [64];
  logic [31:0] exp_data_a [64];
  logic [4:0]  exp_rd_a   [64];
  logic        exp_we_a   [64];
  logic [5:0]  wr_ptr, rd_ptr;
  logic [3:0]  exp_id_f;
  logic [31:0] exp_data_f;
  logic [4:0]  exp_rd_f;
  logic        exp_we_f;

  integer      seed, errors, tests_ok, tests_bad, start_err;
  logic [3:0]  next_id;
  logic [31:0] model_vl;
  logic        model_vill;

  vcoproc_top #(.Vlen(Vlen), .Depth(Depth), .IdWidth(4)) u_vcoproc_top (.*);

  always #5 clk_i = ~clk_i;

  assign exp_id_f   = exp_id_a[rd_ptr];
  assign exp_data_f = exp_data_a[rd_ptr];
  assign exp_rd_f   = exp_rd_a[rd_ptr];
  assign exp_we_f   = exp_we_a[rd_ptr];

  always @(posedge clk_i) begin
    if (rst_ni && result_valid_o && result_ready_i) begin
      rd_ptr <= rd_ptr + 6'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Result checks against the reference queue
  ////////////////////////////////////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && result_ready_i |-> rd_ptr != wr_ptr)
    else begin
      errors++;
      $display("Result with id %h arrived while none was expected", $sampled(result_id_o));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && result_ready_i |-> result_id_o == exp_id_f)
    else begin
      errors++;
      $display("FAIL result_id_o expected %h got %h", $sampled(exp_id_f), $sampled(result_id_o));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && result_ready_i |-> result_data_o == exp_data_f)
    else begin
      errors++;
      $display("FAIL result_data_o expected %h got %h", $sampled(exp_data_f),
               $sampled(result_data_o));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && result_ready_i |-> result_rd_o == exp_rd_f && result_we_o == exp_we_f)
    else begin
      errors++;
      $display("FAIL result_rd_o/result_we_o expected %h/%h got %h/%h", $sampled(exp_rd_f),
               $sampled(exp_we_f), $sampled(result_rd_o), $sampled(result_we_o));
    end

  ////////////////////////////////////////////////////////////
  // Instruction encoding and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_vsetvli(input logic [4:0] rd, rs1, input logic [7:0] vt);
    return {4'b0000, vt, rs1, 3'b111, rd, OpV};
  endfunction

  function automatic logic [31:0] enc_vsetivli(input logic [4:0] rd, uimm,
                                               input logic [7:0] vt);
    return {4'b1100, vt, uimm, 3'b111, rd, OpV};
  endfunction

  function automatic logic [31:0] enc_vsetvl(input logic [4:0] rd, rs1, rs2);
    return {7'b1000000, rs2, rs1, 3'b111, rd, OpV};
  endfunction

  function automatic logic [31:0] enc_vadd(input logic [4:0] vd);
    return {7'b0000001, 5'd2, 5'd1, 3'b000, vd, OpV};
  endfunction

  // Zero marks an illegal vtype
  function automatic logic [31:0] vlmax_of(input logic [31:0] vt);
    if (vt[31:8] != 0 || vt[5] || vt[2]) begin
      return 0;
    end
    return (32'(Vlen) << vt[1:0]) >> (3 + vt[4:3]);
  endfunction

  task automatic expect_result(input logic [3:0] id, input logic [31:0] data,
                               input logic [4:0] rd, input logic we);
    exp_id_a[wr_ptr]   = id;
    exp_data_a[wr_ptr] = data;
    exp_rd_a[wr_ptr]   = rd;
    exp_we_a[wr_ptr]   = we;
    wr_ptr             = wr_ptr + 6'd1;
  endtask

  // kind 0 vsetvli, 1 vsetivli (rs1f is the immediate), 2 vsetvl
  task automatic model_cfg(input int kind, input logic [4:0] rd, rs1f,
                           input logic [31:0] rs1v, vt, input logic [3:0] id);
    logic [31:0] vmax, avl, vl;
    vmax = vlmax_of(vt);
    if (vmax == 0) begin
      vl         = 0;
      model_vill = 1'b1;
    end else begin
      model_vill = 1'b0;
      if (kind != 1 && rs1f == 0 && rd == 0) begin
        vl = model_vl;
      end else begin
        avl = (kind == 1) ? 32'(rs1f) : (rs1f != 0 ? rs1v : vmax);
        vl  = avl < vmax ? avl : vmax;
      end
    end
    model_vl = vl;
    expect_result(id, vl, rd, rd != 0);
  endtask

  ////////////////////////////////////////////////////////////
  // Protocol tasks
  ////////////////////////////////////////////////////////////

  task automatic offer(input logic [31:0] instr, input logic exp_acc, input logic exp_wb,
                       input logic [1:0] exp_rr);
    int waited;
    issue_valid_i = 1'b1;
    issue_instr_i = instr;
    issue_id_i    = next_id;
    waited        = 0;
    @(negedge clk_i);
    while (!issue_ready_o && waited < 100) begin
      waited++;
      @(negedge clk_i);
    end
    if (!issue_ready_o) begin
      errors++;
      $display("Issue of id %h was never taken", next_id);
    end else begin
      assert (issue_accept_o === exp_acc && issue_writeback_o === exp_wb) else begin
        errors++;
        $display("FAIL issue_accept_o/issue_writeback_o expected %h/%h got %h/%h",
                 exp_acc, exp_wb, issue_accept_o, issue_writeback_o);
      end
      assert (issue_register_read_o === exp_rr) else begin
        errors++;
        $display("FAIL issue_register_read_o expected %h got %h", exp_rr,
                 issue_register_read_o);
      end
    end
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b0;
    if (exp_acc) begin
      next_id = next_id + 4'd1;
    end
  endtask

  task automatic send_regs(input logic [3:0] id, input logic [31:0] rs1, rs2);
    int waited;
    register_valid_i = 1'b1;
    register_id_i    = id;
    register_rs1_i   = rs1;
    register_rs2_i   = rs2;
    waited           = 0;
    @(negedge clk_i);
    while (!register_ready_o && waited < 100) begin
      waited++;
      @(negedge clk_i);
    end
    if (!register_ready_o) begin
      errors++;
      $display("Operands for id %h were never taken", id);
    end
    @(posedge clk_i);
    #1;
    register_valid_i = 1'b0;
  endtask

  task automatic commit(input logic [3:0] id, input logic kill);
    commit_valid_i = 1'b1;
    commit_id_i    = id;
    commit_kill_i  = kill;
    @(posedge clk_i);
    #1;
    commit_valid_i = 1'b0;
    commit_kill_i  = 1'b0;
  endtask

  task automatic run_cfg(input int kind, input logic [4:0] rd, rs1f,
                         input logic [31:0] rs1v, vt);
    logic [3:0]  id;
    logic [31:0] instr;
    id = next_id;
    if (kind == 0) begin
      instr = enc_vsetvli(rd, rs1f, vt[7:0]);
    end else begin
      instr = enc_vsetivli(rd, rs1f, vt[7:0]);
    end
    model_cfg(kind, rd, rs1f, rs1v, vt, id);
    offer(instr, 1'b1, rd != 0, (kind == 0) ? 2'b01 : 2'b00);
    if (kind == 0) begin
      send_regs(id, rs1v, 32'h0);
    end
    commit(id, 1'b0);
  endtask

  // Acceptance follows the modelled vill state
  task automatic run_arith(input logic [4:0] vd);
    logic [3:0] id;
    logic       exp_acc;
    id      = next_id;
    exp_acc = !model_vill;
    if (exp_acc) begin
      expect_result(id, 32'h0, vd, 1'b0);
    end
    offer(enc_vadd(vd), exp_acc, 1'b0, 2'b00);
    if (exp_acc) begin
      commit(id, 1'b0);
    end
  endtask

  task automatic wait_results();
    int waited;
    waited = 0;
    while (rd_ptr != wr_ptr && waited < 200) begin
      waited++;
      @(posedge clk_i);
    end
    if (rd_ptr != wr_ptr) begin
      errors++;
      $display("Expected results never arrived");
    end
    #1;
  endtask

  task automatic end_test(input string name);
    if (errors == start_err) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: failed", name);
    end
    start_err = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [3:0]  id;
    logic [31:0] avl;
    seed = 32'h86b0_46a8;
    {errors, tests_ok, tests_bad, start_err} = '0;
    {wr_ptr, rd_ptr, next_id} = '0;
    model_vl = 0;
    model_vill = 1'b1;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {issue_valid_i, register_valid_i, commit_valid_i, commit_kill_i} = '0;
    {issue_instr_i, issue_id_i, register_id_i, commit_id_i} = '0;
    {register_rs1_i, register_rs2_i} = '0;
    result_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // vill out of reset, illegal vtype, then legal
    run_arith(5'd1);
    run_cfg(1, 5'd2, 5'd9, 0, 32'h04);
    run_arith(5'd1);
    run_cfg(1, 5'd2, 5'd9, 0, 32'h00);
    run_arith(5'd3);
    wait_results();
    end_test("vill gating");

    run_cfg(0, 5'd3, 5'd5, $random(seed) & 32'h3f, 32'h11);
    run_cfg(0, 5'd4, 5'd0, 0, 32'h00);
    run_cfg(1, 5'd6, 5'd7, 0, 32'h0a);
    repeat (4) begin
      avl = $random(seed) & 32'h7f;
      run_cfg(0, 5'd8, 5'd10, avl, {27'h0, avl[1:0], 1'b0, avl[3:2]});
    end
    wait_results();
    end_test("vl computation");

    id = next_id;
    avl = $random(seed) & 32'h1f;
    model_cfg(2, 5'd7, 5'd8, avl, 32'h19, id);
    offer(enc_vsetvl(5'd7, 5'd8, 5'd9), 1'b1, 1'b1, 2'b11);
    issue_valid_i = 1'b1;
    issue_instr_i = enc_vadd(5'd4);
    issue_id_i    = next_id;
    repeat (3) begin
      @(negedge clk_i);
      assert (!issue_ready_o) else begin
        errors++;
        $display("FAIL issue_ready_o expected 0 got %h", issue_ready_o);
      end
    end
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b0;
    send_regs(id, avl, 32'h19);
    commit(id, 1'b0);
    run_arith(5'd4);
    wait_results();
    end_test("vsetvl stall");

    offer(32'h0050_0093, 1'b0, 1'b0, 2'b00);
    run_cfg(1, 5'd1, 5'd3, 0, 32'h00);
    wait_results();
    end_test("foreign instruction");

    // X fills the result port and keeps committed A in the buffer
    result_ready_i = 1'b0;
    run_cfg(1, 5'd1, 5'd4, 0, 32'h08);
    run_cfg(1, 5'd2, 5'd5, 0, 32'h09);
    offer(enc_vsetivli(5'd3, 5'd6, 8'h00), 1'b1, 1'b1, 2'b00);
    offer(enc_vsetivli(5'd4, 5'd7, 8'h00), 1'b1, 1'b1, 2'b00);
    commit(4'h0, 1'b1);
    result_ready_i = 1'b1;
    run_arith(5'd5);
    wait_results();
    end_test("kill flush");

    result_ready_i = 1'b0;
    repeat (Depth + 1) begin
      run_cfg(1, 5'd6, 5'(($random(seed) & 32'h1f)), 0, 32'h10);
    end
    repeat (4) @(posedge clk_i);
    #1;
    issue_valid_i = 1'b1;
    issue_instr_i = enc_vadd(5'd7);
    issue_id_i    = next_id;
    repeat (3) begin
      @(negedge clk_i);
      assert (!issue_ready_o) else begin
        errors++;
        $display("FAIL issue_ready_o expected 0 got %h", issue_ready_o);
      end
    end
    @(posedge clk_i);
    #1;
    issue_valid_i  = 1'b0;
    result_ready_i = 1'b1;
    wait_results();
    end_test("back-pressure");

    $display("tests: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #1000000;
    $display("Simulation ran past its time limit");
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* vcfg_execute.sv */
// Vector configuration execute stage
`timescale 1ns/1ps

module vcfg_execute #(
  parameter int unsigned Vlen    = rvv_pkg::VlenDefault,
  parameter int unsigned IdWidth = xif_pkg::IdWidth
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               exec_valid_i,
  output logic               exec_ready_o,
  input  logic [IdWidth-1:0] exec_id_i,
  input  xif_pkg::instr_t    exec_instr_i,
  input  logic               exec_cfg_i,
  input  xif_pkg::rd_addr_t  exec_rd_i,
  input  xif_pkg::xreg_t     exec_rs1_i,
  input  xif_pkg::xreg_t     exec_rs2_i,
  output logic               arch_vill_o,
  output logic               res_valid_o,
  input  logic               res_ready_i,
  output logic [IdWidth-1:0] res_id_o,
  output rvv_pkg::vl_t       res_data_o,
  output xif_pkg::rd_addr_t  res_rd_o,
  output logic               res_we_o
);
  import rvv_pkg::*;

  // Architectural state
  vl_t    vl_q, vl_d;
  vtype_t vtype_q, vtype_d;

  vl_t    max_vl, avl;
  logic   rd_zero, rs1_zero, fire;

  assign fire         = exec_valid_i && res_ready_i;
  assign exec_ready_o = res_ready_i;
  assign rd_zero      = exec_rd_i == 5'd0;
  assign rs1_zero     = exec_instr_i[19:15] == 5'd0;

  always_comb begin
    if (is_vsetvl(exec_instr_i)) begin
      vtype_d = vtype_from_bits(exec_rs2_i, Vlen);
    end else begin
      vtype_d = vtype_from_bits(imm_vtype(exec_instr_i), Vlen);
    end
    max_vl = vlmax(Vlen, vtype_d);

    // AVL from the immediate, rs1, or vlmax for rs1 = x0
    if (is_vsetivli(exec_instr_i)) begin
      avl = vl_t'(exec_instr_i[19:15]);
    end else if (!rs1_zero) begin
      avl = exec_rs1_i;
    end else begin
      avl = max_vl;
    end

    if (vtype_d[VillBit]) begin
      vl_d = '0;
    end else if (!is_vsetivli(exec_instr_i) && rs1_zero && rd_zero) begin
      vl_d = vl_q;
    end else if (avl < max_vl) begin
      vl_d = avl;
    end else begin
      vl_d = max_vl;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vl_q    <= '0;
      vtype_q <= VtypeIll;
    end else if (fire && exec_cfg_i) begin
      vl_q    <= vl_d;
      vtype_q <= vtype_d;
    end
  end

  assign arch_vill_o = vtype_q[VillBit];

  // Arithmetic retires without writeback
  assign res_valid_o = exec_valid_i;
  assign res_id_o    = exec_id_i;
  assign res_rd_o    = exec_rd_i;
  assign res_we_o    = exec_cfg_i && !rd_zero;
  assign res_data_o  = exec_cfg_i ? vl_d : '0;

endmodule

/* vcoproc_top.sv */
// Vector coprocessor offload front end
`timescale 1ns/1ps

module vcoproc_top #(
  parameter int unsigned Vlen    = rvv_pkg::VlenDefault,
  parameter int unsigned Depth   = 4,
  parameter int unsigned IdWidth = xif_pkg::IdWidth
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Issue
  input  logic               issue_valid_i,
  output logic               issue_ready_o,
  input  xif_pkg::instr_t    issue_instr_i,
  input  logic [IdWidth-1:0] issue_id_i,
  output logic               issue_accept_o,
  output logic               issue_writeback_o,
  output logic [1:0]         issue_register_read_o,
  // Register
  input  logic               register_valid_i,
  output logic               register_ready_o,
  input  logic [IdWidth-1:0] register_id_i,
  input  xif_pkg::xreg_t     register_rs1_i,
  input  xif_pkg::xreg_t     register_rs2_i,
  // Commit
  input  logic               commit_valid_i,
  input  logic [IdWidth-1:0] commit_id_i,
  input  logic               commit_kill_i,
  // Result
  output logic               result_valid_o,
  input  logic               result_ready_i,
  output logic [IdWidth-1:0] result_id_o,
  output xif_pkg::xreg_t     result_data_o,
  output xif_pkg::rd_addr_t  result_rd_o,
  output logic               result_we_o
);
  import xif_pkg::*;
  import rvv_pkg::*;

  // Decoder and buffer
  logic               full, flush, drain, arch_vill;
  logic               push, push_cfg;
  rd_addr_t           push_rd;

  // Buffer to execute
  logic               exec_valid, exec_ready, exec_cfg;
  logic [IdWidth-1:0] exec_id;
  instr_t             exec_instr;
  rd_addr_t           exec_rd;
  xreg_t              exec_rs1, exec_rs2;

  // Execute to result port
  logic               res_valid, res_ready, res_we;
  logic [IdWidth-1:0] res_id;
  vl_t                res_data;
  rd_addr_t           res_rd;

  coproc_issue_decoder #(
    .Vlen   (Vlen),
    .IdWidth(IdWidth)
  ) u_coproc_issue_decoder (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .issue_valid_i        (issue_valid_i),
    .issue_instr_i        (issue_instr_i),
    .issue_id_i           (issue_id_i),
    .issue_ready_o        (issue_ready_o),
    .issue_accept_o       (issue_accept_o),
    .issue_writeback_o    (issue_writeback_o),
    .issue_register_read_o(issue_register_read_o),
    .register_valid_i     (register_valid_i),
    .register_id_i        (register_id_i),
    .register_rs2_i       (register_rs2_i),
    .full_i               (full),
    .flush_i              (flush),
    .drain_i              (drain),
    .arch_vill_i          (arch_vill),
    .push_o               (push),
    .push_cfg_o           (push_cfg),
    .push_rd_o            (push_rd)
  );

  instr_ring_buffer #(
    .Depth  (Depth),
    .IdWidth(IdWidth)
  ) u_instr_ring_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .push_i          (push),
    .push_id_i       (issue_id_i),
    .push_instr_i    (issue_instr_i),
    .push_cfg_i      (push_cfg),
    .push_rd_i       (push_rd),
    .push_needs_rs_i (issue_register_read_o),
    .register_valid_i(register_valid_i),
    .register_id_i   (register_id_i),
    .register_rs1_i  (register_rs1_i),
    .register_rs2_i  (register_rs2_i),
    .register_ready_o(register_ready_o),
    .commit_valid_i  (commit_valid_i),
    .commit_id_i     (commit_id_i),
    .commit_kill_i   (commit_kill_i),
    .full_o          (full),
    .flush_o         (flush),
    .drain_o         (drain),
    .exec_valid_o    (exec_valid),
    .exec_ready_i    (exec_ready),
    .exec_id_o       (exec_id),
    .exec_instr_o    (exec_instr),
    .exec_cfg_o      (exec_cfg),
    .exec_rd_o       (exec_rd),
    .exec_rs1_o      (exec_rs1),
    .exec_rs2_o      (exec_rs2)
  );

  vcfg_execute #(
    .Vlen   (Vlen),
    .IdWidth(IdWidth)
  ) u_vcfg_execute (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .exec_valid_i(exec_valid),
    .exec_ready_o(exec_ready),
    .exec_id_i   (exec_id),
    .exec_instr_i(exec_instr),
    .exec_cfg_i  (exec_cfg),
    .exec_rd_i   (exec_rd),
    .exec_rs1_i  (exec_rs1),
    .exec_rs2_i  (exec_rs2),
    .arch_vill_o (arch_vill),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .res_id_o    (res_id),
    .res_data_o  (res_data),
    .res_rd_o    (res_rd),
    .res_we_o    (res_we)
  );

  result_port #(
    .IdWidth(IdWidth)
  ) u_result_port (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .res_valid_i   (res_valid),
    .res_ready_o   (res_ready),
    .res_id_i      (res_id),
    .res_data_i    (res_data),
    .res_rd_i      (res_rd),
    .res_we_i      (res_we),
    .result_valid_o(result_valid_o),
    .result_ready_i(result_ready_i),
    .result_id_o   (result_id_o),
    .result_data_o (result_data_o),
    .result_rd_o   (result_rd_o),
    .result_we_o   (result_we_o)
  );

endmodule

/* xif_pkg.sv */
// Offload protocol definitions
package xif_pkg;

  // Default width of an offload instruction id
  parameter int unsigned IdWidth = 4;

  // Scalar register width of the core
  parameter int unsigned Xlen = 32;

  // Offloaded instruction word
  typedef logic [31:0] instr_t;

  // Scalar operand or result
  typedef logic [Xlen-1:0] xreg_t;

  // Destination register index
  typedef logic [4:0] rd_addr_t;

endpackage
